//--- soc_pkg.sv
package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;  // all zero means read

  localparam addr_t ram_base_addr = 32'h0000_0000;
  localparam addr_t ram_top_addr = 32'h0000_0400;  // 256 words

  localparam addr_t timer_base_addr = 32'h0200_0000;
  localparam addr_t timer_top_addr = 32'h0200_0020;

  localparam addr_t uart_base_addr = 32'h1000_0000;
  localparam addr_t uart_top_addr = 32'h1000_0010;

  // timer register offsets
  localparam addr_t timer_msip_off = 32'd0;
  localparam addr_t timer_cmp_lo_off = 32'd4;
  localparam addr_t timer_cmp_hi_off = 32'd8;
  localparam addr_t timer_time_lo_off = 32'd12;
  localparam addr_t timer_time_hi_off = 32'd16;

  // uart register offsets
  localparam addr_t uart_data_off = 32'd0;  // write only
  localparam addr_t uart_status_off = 32'd4;  // bit 0 busy

endpackage

//--- periph_decoder.sv
module periph_decoder (
  input  logic            clock,
  input  logic            reset,
  input  logic            mem_valid,
  input  soc_pkg::addr_t  mem_addr,
  input  soc_pkg::data_t  mem_wdata,
  input  soc_pkg::strb_t  mem_wstrb,
  output logic            mem_ready,
  output soc_pkg::data_t  mem_rdata,
  output logic            mem_error,
  output logic            ram_valid,
  output logic            timer_valid,
  output logic            uart_valid,
  output soc_pkg::addr_t  tgt_addr,
  output soc_pkg::data_t  tgt_wdata,
  output soc_pkg::strb_t  tgt_wstrb,
  input  logic            ram_ready,
  input  soc_pkg::data_t  ram_rdata,
  input  logic            timer_ready,
  input  soc_pkg::data_t  timer_rdata,
  input  logic            uart_ready,
  input  soc_pkg::data_t  uart_rdata
);

  import soc_pkg::*;

  typedef enum logic [2:0] {
    own_none,
    own_ram,
    own_timer,
    own_uart,
    own_unmapped
  } owner_t;

  owner_t owner;
  owner_t next_owner;
  addr_t  base_addr;

  function automatic logic in_window(addr_t addr, addr_t base, addr_t top);
    return (addr >= base) && (addr < top);
  endfunction

  always_comb begin
    ram_valid   = 1'b0;
    timer_valid = 1'b0;
    uart_valid  = 1'b0;
    base_addr   = '0;
    next_owner  = own_unmapped;  // nothing matched
    if (in_window(mem_addr, ram_base_addr, ram_top_addr)) begin
      ram_valid  = mem_valid;
      base_addr  = ram_base_addr;
      next_owner = own_ram;
    end else if (in_window(mem_addr, timer_base_addr, timer_top_addr)) begin
      timer_valid = mem_valid;
      base_addr   = timer_base_addr;
      next_owner  = own_timer;
    end else if (in_window(mem_addr, uart_base_addr, uart_top_addr)) begin
      uart_valid = mem_valid;
      base_addr  = uart_base_addr;
      next_owner = own_uart;
    end
  end

  assign tgt_addr  = mem_addr - base_addr;
  assign tgt_wdata = mem_wdata;
  assign tgt_wstrb = mem_wstrb;

  // owner of the request in flight, cleared with its response
  always_ff @(posedge clock) begin
    if (!reset) begin
      owner <= own_none;
    end else if (mem_valid) begin
      owner <= next_owner;
    end else if (mem_ready) begin
      owner <= own_none;
    end
  end

  always_comb begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    mem_error = 1'b0;
    case (owner)
      own_ram: begin
        mem_ready = ram_ready;
        mem_rdata = ram_ready ? ram_rdata : '0;
      end
      own_timer: begin
        mem_ready = timer_ready;
        mem_rdata = timer_ready ? timer_rdata : '0;
      end
      own_uart: begin
        mem_ready = uart_ready;
        mem_rdata = uart_ready ? uart_rdata : '0;
      end
      own_unmapped: begin
        mem_ready = 1'b1;  // error reply, rdata stays zero
        mem_error = 1'b1;
      end
      default: ;
    endcase
  end

  a_one_ready: assert property (@(posedge clock) disable iff (!reset)
    $onehot0({ram_ready, timer_ready, uart_ready}))
    else $error("more than one target ready");

  a_one_in_flight: assert property (@(posedge clock) disable iff (!reset)
    mem_valid |-> owner == own_none)
    else $error("request issued while another is pending");

endmodule

//--- scratch_ram.sv
module scratch_ram #(
  parameter int ram_words = 256
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            valid,
  input  soc_pkg::addr_t  addr,
  input  soc_pkg::data_t  wdata,
  input  soc_pkg::strb_t  wstrb,
  output logic            ready,
  output soc_pkg::data_t  rdata
);

  import soc_pkg::*;

  localparam int idx_w = $clog2(ram_words);

  data_t            mem [ram_words];
  logic [idx_w-1:0] idx;
  logic             write;

  assign idx   = addr[idx_w+1:2];  // word index
  assign write = valid && (wstrb != '0);

  always_ff @(posedge clock) begin
    if (write) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem[idx][8*i+:8] <= wdata[8*i+:8];
        end
      end
    end
    if (valid) begin
      rdata <= write ? '0 : mem[idx];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid;  // fixed one cycle latency
    end
  end

endmodule

//--- core_timer.sv
module core_timer #(
  parameter int rtc_divider = 50
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            valid,
  input  soc_pkg::addr_t  addr,
  input  soc_pkg::data_t  wdata,
  input  soc_pkg::strb_t  wstrb,
  output logic            ready,
  output soc_pkg::data_t  rdata,
  output logic            msip,
  output logic            mtip
);

  import soc_pkg::*;

  localparam int pre_w = (rtc_divider > 1) ? $clog2(rtc_divider) : 1;

  logic [pre_w-1:0] prescale;
  logic             tick;
  logic [63:0]      mtime;
  logic [63:0]      mtimecmp;
  logic             write;
  data_t            rd_value;

  function automatic data_t merge(data_t old, data_t val, strb_t strb);
    data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i+:8] = val[8*i+:8];
    end
    return res;
  endfunction

  assign write = valid && (wstrb != '0);
  assign tick  = (prescale == pre_w'(rtc_divider - 1));

  always_comb begin
    case (addr)
      timer_msip_off:    rd_value = {31'b0, msip};
      timer_cmp_lo_off:  rd_value = mtimecmp[31:0];
      timer_cmp_hi_off:  rd_value = mtimecmp[63:32];
      timer_time_lo_off: rd_value = mtime[31:0];
      timer_time_hi_off: rd_value = mtime[63:32];
      default:           rd_value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      prescale <= '0;
      mtime    <= '0;
      mtimecmp <= '1;  // keeps mtip low out of reset
      msip     <= 1'b0;
      mtip     <= 1'b0;
      ready    <= 1'b0;
    end else begin
      prescale <= tick ? '0 : prescale + 1'b1;
      if (write && addr == timer_time_lo_off) begin
        mtime[31:0] <= merge(mtime[31:0], wdata, wstrb);
      end else if (write && addr == timer_time_hi_off) begin
        mtime[63:32] <= merge(mtime[63:32], wdata, wstrb);
      end else if (tick) begin
        mtime <= mtime + 64'd1;
      end
      if (write && addr == timer_cmp_lo_off) begin
        mtimecmp[31:0] <= merge(mtimecmp[31:0], wdata, wstrb);
      end
      if (write && addr == timer_cmp_hi_off) begin
        mtimecmp[63:32] <= merge(mtimecmp[63:32], wdata, wstrb);
      end
      if (write && addr == timer_msip_off && wstrb[0]) begin
        msip <= wdata[0];
      end
      mtip  <= (mtime >= mtimecmp);
      ready <= valid;
    end
  end

  always_ff @(posedge clock) begin
    if (valid) begin
      rdata <= write ? '0 : rd_value;
    end
  end

endmodule

//--- uart_tx.sv
module uart_tx #(
  parameter int bit_divider = 434
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            valid,
  input  soc_pkg::addr_t  addr,
  input  soc_pkg::data_t  wdata,
  input  soc_pkg::strb_t  wstrb,
  output logic            ready,
  output soc_pkg::data_t  rdata,
  output logic            tx
);

  import soc_pkg::*;

  localparam int cnt_w = (bit_divider > 1) ? $clog2(bit_divider) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } state_t;

  state_t           state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  logic             held;
  logic [7:0]       held_byte;
  logic             wr_data;
  logic             rd_status;
  logic             last_tick;
  logic             load;
  logic [7:0]       load_byte;
  logic             busy;

  assign wr_data   = valid && (addr == uart_data_off) && (wstrb != '0);
  assign rd_status = valid && (addr == uart_status_off) && (wstrb == '0);
  assign last_tick = (cnt == cnt_w'(bit_divider - 1));
  assign busy      = (state != st_idle);

  // a new frame starts from idle or right at the end of a stop bit
  assign load      = (held || wr_data) && (!busy || (state == st_stop && last_tick));
  assign load_byte = held ? held_byte : wdata[7:0];

  always_ff @(posedge clock) begin
    if (!reset) begin
      state   <= st_idle;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      held    <= 1'b0;
      ready   <= 1'b0;
    end else begin
      ready <= (valid && !wr_data) || load;  // held write answers on load
      cnt   <= last_tick ? '0 : cnt + 1'b1;
      if (load) begin
        held  <= 1'b0;
        shift <= load_byte;
        state <= st_start;
        tx    <= 1'b0;
        cnt   <= '0;
      end else begin
        if (wr_data) begin
          held      <= 1'b1;
          held_byte <= wdata[7:0];
        end
        case (state)
          st_idle: cnt <= '0;
          st_start: if (last_tick) begin
            state   <= st_data;
            bit_idx <= '0;
            tx      <= shift[0];
          end
          st_data: if (last_tick) begin
            if (bit_idx == 3'd7) begin
              state <= st_stop;
              tx    <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              shift   <= shift >> 1;
              tx      <= shift[1];
            end
          end
          st_stop: if (last_tick) state <= st_idle;
          default: state <= st_idle;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (valid) begin
      rdata <= rd_status ? {31'b0, busy} : '0;
    end else if (load) begin
      rdata <= '0;
    end
  end

  a_idle_line_high: assert property (@(posedge clock) disable iff (!reset)
    state == st_idle |-> tx)
    else $error("tx low while uart idle");

endmodule

//--- periph_soc.sv
module periph_soc #(
  parameter int rtc_divider = 50,
  parameter int bit_divider = 434,
  parameter int ram_words   = 256
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            mem_valid,
  input  soc_pkg::addr_t  mem_addr,
  input  soc_pkg::data_t  mem_wdata,
  input  soc_pkg::strb_t  mem_wstrb,
  output logic            mem_ready,
  output soc_pkg::data_t  mem_rdata,
  output logic            mem_error,
  output logic            msip,
  output logic            mtip,
  output logic            tx
);

  import soc_pkg::*;

  logic  ram_valid;
  logic  timer_valid;
  logic  uart_valid;
  logic  ram_ready;
  logic  timer_ready;
  logic  uart_ready;
  addr_t tgt_addr;
  data_t tgt_wdata;
  strb_t tgt_wstrb;
  data_t ram_rdata;
  data_t timer_rdata;
  data_t uart_rdata;

  periph_decoder decoder0 (
    .clock       (clock),
    .reset       (reset),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .mem_error   (mem_error),
    .ram_valid   (ram_valid),
    .timer_valid (timer_valid),
    .uart_valid  (uart_valid),
    .tgt_addr    (tgt_addr),
    .tgt_wdata   (tgt_wdata),
    .tgt_wstrb   (tgt_wstrb),
    .ram_ready   (ram_ready),
    .ram_rdata   (ram_rdata),
    .timer_ready (timer_ready),
    .timer_rdata (timer_rdata),
    .uart_ready  (uart_ready),
    .uart_rdata  (uart_rdata)
  );

  scratch_ram #(.ram_words(ram_words)) ram0 (
    .clock (clock),
    .reset (reset),
    .valid (ram_valid),
    .addr  (tgt_addr),
    .wdata (tgt_wdata),
    .wstrb (tgt_wstrb),
    .ready (ram_ready),
    .rdata (ram_rdata)
  );

  core_timer #(.rtc_divider(rtc_divider)) timer0 (
    .clock (clock),
    .reset (reset),
    .valid (timer_valid),
    .addr  (tgt_addr),
    .wdata (tgt_wdata),
    .wstrb (tgt_wstrb),
    .ready (timer_ready),
    .rdata (timer_rdata),
    .msip  (msip),
    .mtip  (mtip)
  );

  uart_tx #(.bit_divider(bit_divider)) uart0 (
    .clock (clock),
    .reset (reset),
    .valid (uart_valid),
    .addr  (tgt_addr),
    .wdata (tgt_wdata),
    .wstrb (tgt_wstrb),
    .ready (uart_ready),
    .rdata (uart_rdata),
    .tx    (tx)
  );

endmodule

//--- tb_periph_soc.sv
module tb_periph_soc;

  import soc_pkg::*;

  localparam int rtc_divider  = 4;
  localparam int bit_divider  = 8;
  localparam int ram_words    = 256;
  localparam int clock_period = 100;
  localparam int reset_cycles = 10;
  localparam int ram_writes   = 16;
  localparam int ready_limit  = 12 * bit_divider + 8;  // covers a write held for a whole frame
  // 60 bus accesses, the mtip wait, three frames of 10 bits each
  localparam int run_cycles = reset_cycles + 60 * 4 + 8 * rtc_divider + 30 * bit_divider;
  localparam int watchdog_cycles = 2 * run_cycles;

  logic  clock;
  logic  reset;
  logic  mem_valid;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_wstrb;
  logic  mem_ready;
  data_t mem_rdata;
  logic  mem_error;
  logic  msip;
  logic  mtip;
  logic  tx;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] rand_state = 32'ha934_1908;
  data_t       ram_model [ram_words];

  periph_soc #(
    .rtc_divider (rtc_divider),
    .bit_divider (bit_divider),
    .ram_words   (ram_words)
  ) dut0 (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_error (mem_error),
    .msip      (msip),
    .mtip      (mtip),
    .tx        (tx)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("run did not finish within %0d cycles", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

  function automatic logic [31:0] next_random();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t expected);
    checks++;
    if (got !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    $display("test %s done with %0d errors", name, errors - errors_at_start);
  endtask

  // one request pulse, then wait for mem_ready; outputs are sampled at the falling edge
  task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                            output data_t rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge clock);
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= wdata;
    mem_wstrb <= wstrb;
    @(posedge clock);
    mem_valid <= 1'b0;
    @(negedge clock);
    while (!mem_ready && waited < ready_limit) begin
      @(negedge clock);
      waited++;
    end
    rdata = mem_rdata;
    err   = mem_error;
    if (!mem_ready) begin
      report_failure($sformatf("no mem_ready within %0d cycles for address %h",
                               ready_limit, addr));
    end
  endtask

  task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t wstrb,
                           output logic err);
    data_t unused;
    bus_access(addr, wdata, wstrb, unused, err);
  endtask

  task automatic bus_read(input addr_t addr, output data_t rdata, output logic err);
    bus_access(addr, '0, 4'h0, rdata, err);
  endtask

  // bits[0] is the start bit, bits[9] the stop bit, each sampled near mid-bit
  task automatic capture_frame(output logic [9:0] bits, output time stop_time);
    int waited;
    waited = 0;
    bits = '1;
    @(negedge clock);
    while (tx && waited < ready_limit) begin
      @(negedge clock);
      waited++;
    end
    if (tx) begin
      report_failure("no start bit seen on tx");
      stop_time = $time;
    end else begin
      repeat (bit_divider / 2 - 1) @(negedge clock);
      bits[0] = tx;
      for (int i = 1; i < 10; i++) begin
        repeat (bit_divider) @(negedge clock);
        bits[i] = tx;
      end
      stop_time = $time;
    end
  endtask

  task automatic ram_readback();
    int    start;
    addr_t addrs[$];
    addr_t a;
    data_t d;
    data_t got;
    logic  err;
    strb_t strobes[3];
    start = errors;
    strobes = '{4'b0001, 4'b0110, 4'b1000};
    for (int i = 0; i < ram_writes; i++) begin
      a = (next_random() % ram_words) * 4;
      d = next_random();
      bus_write(ram_base_addr + a, d, 4'hf, err);
      check_value("mem_error", data_t'(err), 32'd0);
      ram_model[a[9:2]] = d;
      addrs.push_back(a);
    end
    foreach (addrs[i]) begin
      bus_read(ram_base_addr + addrs[i], got, err);
      check_value("ram word", got, ram_model[addrs[i][9:2]]);
    end
    for (int k = 0; k < 3; k++) begin
      a = addrs[k];
      d = next_random();
      bus_write(ram_base_addr + a, d, strobes[k], err);
      for (int b = 0; b < 4; b++) begin
        if (strobes[k][b]) ram_model[a[9:2]][8*b+:8] = d[8*b+:8];
      end
      bus_read(ram_base_addr + a, got, err);
      check_value("ram partial word", got, ram_model[a[9:2]]);
    end
    report_test("ram", start);
  endtask

  task automatic unmapped_reply();
    int    start;
    data_t got;
    logic  err;
    start = errors;
    bus_read(32'h3000_0000, got, err);
    check_value("mem_error", data_t'(err), 32'd1);
    check_value("mem_rdata", got, 32'd0);
    bus_access(ram_top_addr, next_random(), 4'hf, got, err);  // first byte past the ram
    check_value("mem_error", data_t'(err), 32'd1);
    check_value("mem_rdata", got, 32'd0);
    bus_read(uart_top_addr, got, err);
    check_value("mem_error", data_t'(err), 32'd1);
    check_value("mem_rdata", got, 32'd0);
    bus_read(ram_base_addr, got, err);
    check_value("mem_error", data_t'(err), 32'd0);
    report_test("unmapped", start);
  endtask

  task automatic msip_toggle();
    int    start;
    data_t got;
    logic  err;
    start = errors;
    bus_write(timer_base_addr + timer_msip_off, 32'd1, 4'hf, err);
    check_value("msip", data_t'(msip), 32'd1);
    bus_read(timer_base_addr + timer_msip_off, got, err);
    check_value("msip register", got, 32'd1);
    bus_write(timer_base_addr + timer_msip_off, 32'd0, 4'hf, err);
    check_value("msip", data_t'(msip), 32'd0);
    bus_read(timer_base_addr + timer_msip_off, got, err);
    check_value("msip register", got, 32'd0);
    report_test("msip", start);
  endtask

  task automatic mtime_compare();
    int    start;
    int    waited;
    data_t t1;
    data_t t2;
    data_t cmp;
    logic  err;
    time   t_start;
    longint elapsed;
    start = errors;
    bus_read(timer_base_addr + timer_time_lo_off, t1, err);
    bus_read(timer_base_addr + timer_time_lo_off, t2, err);
    check_value("mtime nondecreasing", data_t'(t2 >= t1), 32'd1);
    t_start = $time;
    bus_write(timer_base_addr + timer_time_lo_off, 32'd0, 4'hf, err);
    bus_read(timer_base_addr + timer_time_lo_off, t1, err);
    elapsed = ($time - t_start) / clock_period;
    check_value("mtime after clear", data_t'(longint'(t1) < elapsed / rtc_divider + 1), 32'd1);
    bus_read(timer_base_addr + timer_time_lo_off, t1, err);
    cmp = t1 + 32'd5;
    bus_write(timer_base_addr + timer_cmp_hi_off, 32'd0, 4'hf, err);
    bus_write(timer_base_addr + timer_cmp_lo_off, cmp, 4'hf, err);
    @(negedge clock);  // mtip now reflects the new compare value
    check_value("mtip", data_t'(mtip), 32'd0);
    waited = 0;
    while (!mtip && waited < 8 * rtc_divider) begin
      @(negedge clock);
      waited++;
    end
    if (!mtip) report_failure("mtip did not rise after mtime reached mtimecmp");
    bus_read(timer_base_addr + timer_time_lo_off, t2, err);
    check_value("mtime at mtip", data_t'(t2 >= cmp), 32'd1);
    report_test("mtime", start);
  endtask

  task automatic uart_frame();
    int         start;
    logic [7:0] tx_byte;
    logic [9:0] bits;
    time        stop_time;
    data_t      status;
    logic       err;
    start = errors;
    tx_byte = 8'(next_random());
    fork
      capture_frame(bits, stop_time);
      begin
        bus_write(uart_base_addr + uart_data_off, {24'b0, tx_byte}, 4'hf, err);
        repeat (3 * bit_divider) @(negedge clock);  // well inside the frame
        bus_read(uart_base_addr + uart_status_off, status, err);
        check_value("uart busy", status, 32'd1);
      end
    join
    check_value("tx start bit", data_t'(bits[0]), 32'd0);
    check_value("tx data byte", data_t'(bits[8:1]), data_t'(tx_byte));
    check_value("tx stop bit", data_t'(bits[9]), 32'd1);
    repeat (bit_divider) @(negedge clock);  // let the stop bit finish
    bus_read(uart_base_addr + uart_status_off, status, err);
    check_value("uart busy", status, 32'd0);
    report_test("uart_frame", start);
  endtask

  task automatic uart_backpressure();
    int         start;
    logic [7:0] byte1;
    logic [7:0] byte2;
    logic [9:0] bits1;
    logic [9:0] bits2;
    time        stop1;
    time        stop2;
    time        ready2;
    logic       err;
    start = errors;
    byte1 = 8'(next_random());
    byte2 = 8'(next_random());
    fork
      begin
        capture_frame(bits1, stop1);
        capture_frame(bits2, stop2);
      end
      begin
        bus_write(uart_base_addr + uart_data_off, {24'b0, byte1}, 4'hf, err);
        bus_write(uart_base_addr + uart_data_off, {24'b0, byte2}, 4'hf, err);
        ready2 = $time;
      end
    join
    check_value("held write after stop bit", data_t'(ready2 > stop1), 32'd1);
    check_value("first frame", data_t'(bits1), data_t'({1'b1, byte1, 1'b0}));
    check_value("second frame", data_t'(bits2), data_t'({1'b1, byte2, 1'b0}));
    report_test("uart_backpressure", start);
  endtask

  initial begin
    reset     = 1'b0;
    mem_valid = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b1;
    ram_readback();
    unmapped_reply();
    msip_toggle();
    mtime_compare();
    uart_frame();
    uart_backpressure();
    $display("6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
soc_pkg.sv
periph_decoder.sv
scratch_ram.sv
core_timer.sv
uart_tx.sv
periph_soc.sv
tb_periph_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the peripheral testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_periph_soc \
  -o sim_periph_soc

./obj_dir/sim_periph_soc | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "testbench reported a failure, see sim.log"
  exit 1
fi

echo "run complete, log in sim.log"
exit 0
